/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    // command opcode, bit 4 clear selects an alu operation
    typedef logic [4:0] opcode_t;

    // alu operation code, the low nibble of an alu opcode
    typedef logic [3:0] alu_op_t;

    // fault code reported with done
    typedef logic [1:0] fault_t;

    // alu codes
    localparam alu_op_t IADD = 4'h0;
    localparam alu_op_t ISUB = 4'h1;
    localparam alu_op_t IMUL = 4'h2;
    localparam alu_op_t IDIV = 4'h3;
    localparam alu_op_t IREM = 4'h4;
    localparam alu_op_t INEG = 4'h5;
    localparam alu_op_t IOR  = 4'h8;
    localparam alu_op_t IXOR = 4'h9;
    localparam alu_op_t ISHL = 4'hC;
    localparam alu_op_t ISHR = 4'hD;
    localparam alu_op_t IAND = 4'hF;

    // stack manipulation opcodes
    localparam opcode_t OP_PUSH = 5'h10;
    localparam opcode_t OP_POP  = 5'h11;
    localparam opcode_t OP_DUP  = 5'h12;
    localparam opcode_t OP_SWAP = 5'h13;

    // fault codes
    localparam fault_t FAULT_NONE      = 2'd0;
    localparam fault_t FAULT_UNDERFLOW = 2'd1;
    localparam fault_t FAULT_OVERFLOW  = 2'd2;
    localparam fault_t FAULT_ILLEGAL   = 2'd3;

endpackage

`default_nettype wire

/* hw/stack_pkg.sv */
`default_nettype none

package stack_pkg;

    // one stack entry
    typedef logic [31:0] word_t;

    // number of entries the stack holds
    localparam int STACK_DEPTH = 8;

    // live entry count, 0 to 8
    typedef logic [3:0] depth_t;

    // entry index into the register array
    typedef logic [2:0] sp_t;

endpackage

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  stack_pkg::word_t operand_a,
    input  stack_pkg::word_t operand_b,
    input  isa_pkg::alu_op_t op_select,
    output stack_pkg::word_t result
);

    import isa_pkg::*;

    // mul, div and rem only see the low halves
    logic [15:0] a_lo;
    logic [15:0] b_lo;
    logic [4:0]  shamt;

    assign a_lo  = operand_a[15:0];
    assign b_lo  = operand_b[15:0];
    // shift amount taken modulo 32
    assign shamt = operand_b[4:0];

    always_comb begin
        case (op_select)
            IADD: result = operand_a + operand_b;
            ISUB: result = operand_a - operand_b;
            // full 32-bit product of the two halves
            IMUL: result = a_lo * b_lo;
            IDIV: begin
                if (b_lo == 16'd0) begin
                    result = 32'hFFFF_FFFF;
                end else begin
                    result = a_lo / b_lo;
                end
            end
            IREM: begin
                // remainder by zero hands back the dividend
                if (b_lo == 16'd0) begin
                    result = {16'd0, a_lo};
                end else begin
                    result = a_lo % b_lo;
                end
            end
            // bitwise complement of the single operand
            INEG: result = ~operand_a;
            IOR:  result = operand_a | operand_b;
            IXOR: result = operand_a ^ operand_b;
            IAND: result = operand_a & operand_b;
            ISHL: result = operand_a << shamt;
            ISHR: result = operand_a >> shamt;
            // undefined codes are never committed
            default: result = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/operand_stack.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_stack (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic              pop,
    input  logic              pop_write,
    input  logic              write_top,
    input  logic              swap,
    input  stack_pkg::word_t  wr_data,
    output stack_pkg::word_t  top,
    output stack_pkg::word_t  next,
    output stack_pkg::depth_t depth
);

    import stack_pkg::*;

    word_t  entries [STACK_DEPTH];
    depth_t count;
    sp_t    top_idx;
    sp_t    next_idx;
    sp_t    free_idx;

    // entry 0 is the bottom of the stack
    assign free_idx = count[2:0];
    assign top_idx  = sp_t'(count - 4'd1);
    assign next_idx = sp_t'(count - 4'd2);

    assign top   = (count != 4'd0) ? entries[top_idx] : '0;
    assign next  = (count >= 4'd2) ? entries[next_idx] : '0;
    assign depth = count;

    // depth count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (push) begin
            count <= count + 4'd1;
        end else if (pop || pop_write) begin
            count <= count - 4'd1;
        end
    end

    // register array, the controller never asks for more than one strobe
    always_ff @(posedge clk) begin
        if (push) begin
            entries[free_idx] <= wr_data;
        end
        if (pop_write) begin
            entries[next_idx] <= wr_data;
        end
        if (write_top) begin
            entries[top_idx] <= wr_data;
        end
        if (swap) begin
            entries[top_idx]  <= entries[next_idx];
            entries[next_idx] <= entries[top_idx];
        end
    end

endmodule

`default_nettype wire

/* hw/stack_control.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_control (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  isa_pkg::opcode_t  cmd_op,
    input  stack_pkg::word_t  cmd_imm,
    input  stack_pkg::word_t  top,
    input  stack_pkg::word_t  next,
    input  stack_pkg::depth_t depth,
    input  stack_pkg::word_t  alu_result,
    output isa_pkg::alu_op_t  alu_op,
    output stack_pkg::word_t  operand_a,
    output stack_pkg::word_t  operand_b,
    output logic              push,
    output logic              pop,
    output logic              pop_write,
    output logic              write_top,
    output logic              swap,
    output stack_pkg::word_t  wr_data,
    output logic              done,
    output logic              fault,
    output isa_pkg::fault_t   fault_code
);

    import isa_pkg::*;
    import stack_pkg::*;

    logic   is_alu;
    logic   alu_legal;
    logic   is_unary;
    logic   full;
    fault_t fault_c;
    logic   push_c;
    logic   pop_c;
    logic   pop_write_c;
    logic   write_top_c;
    logic   swap_c;

    assign is_alu   = ~cmd_op[4];
    assign alu_op   = cmd_op[3:0];
    assign is_unary = (alu_op == INEG);
    assign full     = (depth >= depth_t'(STACK_DEPTH));

    always_comb begin
        case (alu_op)
            IADD, ISUB, IMUL, IDIV, IREM, INEG,
            IOR, IXOR, ISHL, ISHR, IAND: alu_legal = 1'b1;
            default:                     alu_legal = 1'b0;
        endcase
    end

    // a is the deeper word, ineg works on the top alone
    assign operand_a = is_unary ? top : next;
    assign operand_b = top;

    always_comb begin
        fault_c     = FAULT_NONE;
        push_c      = 1'b0;
        pop_c       = 1'b0;
        pop_write_c = 1'b0;
        write_top_c = 1'b0;
        swap_c      = 1'b0;
        if (is_alu) begin
            // legality first, then depth
            if (!alu_legal) begin
                fault_c = FAULT_ILLEGAL;
            end else if (is_unary) begin
                if (depth < 4'd1) begin
                    fault_c = FAULT_UNDERFLOW;
                end else begin
                    write_top_c = 1'b1;
                end
            end else if (depth < 4'd2) begin
                fault_c = FAULT_UNDERFLOW;
            end else begin
                pop_write_c = 1'b1;
            end
        end else begin
            case (cmd_op)
                OP_PUSH: begin
                    if (full) fault_c = FAULT_OVERFLOW;
                    else      push_c  = 1'b1;
                end
                OP_POP: begin
                    if (depth < 4'd1) fault_c = FAULT_UNDERFLOW;
                    else              pop_c   = 1'b1;
                end
                OP_DUP: begin
                    if (depth < 4'd1) fault_c = FAULT_UNDERFLOW;
                    else if (full)    fault_c = FAULT_OVERFLOW;
                    else              push_c  = 1'b1;
                end
                OP_SWAP: begin
                    if (depth < 4'd2) fault_c = FAULT_UNDERFLOW;
                    else              swap_c  = 1'b1;
                end
                default: fault_c = FAULT_ILLEGAL;
            endcase
        end
    end

    // strobes only while a command is presented
    assign push      = cmd_valid & push_c;
    assign pop       = cmd_valid & pop_c;
    assign pop_write = cmd_valid & pop_write_c;
    assign write_top = cmd_valid & write_top_c;
    assign swap      = cmd_valid & swap_c;

    assign wr_data = (cmd_op == OP_PUSH) ? cmd_imm :
                     (cmd_op == OP_DUP)  ? top     : alu_result;

    // status for the command, one cycle after its edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done       <= 1'b0;
            fault      <= 1'b0;
            fault_code <= FAULT_NONE;
        end else begin
            done       <= cmd_valid;
            fault      <= cmd_valid && (fault_c != FAULT_NONE);
            fault_code <= cmd_valid ? fault_c : FAULT_NONE;
        end
    end

endmodule

`default_nettype wire

/* hw/stack_core.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  isa_pkg::opcode_t  cmd_op,
    input  stack_pkg::word_t  cmd_imm,
    output logic              done,
    output logic              fault,
    output isa_pkg::fault_t   fault_code,
    output stack_pkg::word_t  tos,
    output stack_pkg::depth_t depth
);

    import isa_pkg::*;
    import stack_pkg::*;

    word_t   top;
    word_t   next;
    word_t   wr_data;
    word_t   operand_a;
    word_t   operand_b;
    word_t   alu_result;
    alu_op_t alu_op;
    logic    push;
    logic    pop;
    logic    pop_write;
    logic    write_top;
    logic    swap;

    assign tos = top;

    stack_control u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_imm    (cmd_imm),
        .top        (top),
        .next       (next),
        .depth      (depth),
        .alu_result (alu_result),
        .alu_op     (alu_op),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .push       (push),
        .pop        (pop),
        .pop_write  (pop_write),
        .write_top  (write_top),
        .swap       (swap),
        .wr_data    (wr_data),
        .done       (done),
        .fault      (fault),
        .fault_code (fault_code)
    );

    operand_stack u_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .pop       (pop),
        .pop_write (pop_write),
        .write_top (write_top),
        .swap      (swap),
        .wr_data   (wr_data),
        .top       (top),
        .next      (next),
        .depth     (depth)
    );

    alu u_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op_select (alu_op),
        .result    (alu_result)
    );

endmodule

`default_nettype wire

/* verification/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/stack_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stack_core_tb;

    import isa_pkg::*;
    import stack_pkg::*;

    localparam int NUM_ROWS    = 38;
    localparam int RANDOM_CMDS = 200;
    localparam int CYCLE_LIMIT = (NUM_ROWS + RANDOM_CMDS) * 2 + 50;

    logic    clk;
    logic    rst_n;
    logic    cmd_valid;
    opcode_t cmd_op;
    word_t   cmd_imm;
    logic    done;
    logic    fault;
    fault_t  fault_code;
    word_t   tos;
    depth_t  depth;

    // directed stimulus with expected state after each command
    opcode_t tbl_op    [NUM_ROWS];
    word_t   tbl_imm   [NUM_ROWS];
    word_t   tbl_tos   [NUM_ROWS];
    depth_t  tbl_depth [NUM_ROWS];
    fault_t  tbl_fault [NUM_ROWS];
    int      row_count;

    // reference model, entry 0 is the bottom
    word_t   m_stack [STACK_DEPTH];
    int      m_depth;

    int      errors;
    int      checks;
    int      cycle_count;
    integer  seed;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    stack_core u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_imm    (cmd_imm),
        .done       (done),
        .fault      (fault),
        .fault_code (fault_code),
        .tos        (tos),
        .depth      (depth)
    );

    task automatic add_row(input opcode_t op, input word_t imm, input word_t exp_tos,
                           input depth_t exp_depth, input fault_t exp_fault);
        tbl_op[row_count]    = op;
        tbl_imm[row_count]   = imm;
        tbl_tos[row_count]   = exp_tos;
        tbl_depth[row_count] = exp_depth;
        tbl_fault[row_count] = exp_fault;
        row_count++;
    endtask

    task automatic fill_table();
        add_row(OP_POP,        32'h0000_0000, 32'h0000_0000, 4'd0, FAULT_UNDERFLOW);
        add_row(5'h06,         32'h0000_0000, 32'h0000_0000, 4'd0, FAULT_ILLEGAL);
        add_row(OP_PUSH,       32'h0000_0005, 32'h0000_0005, 4'd1, FAULT_NONE);
        add_row({1'b0, IADD},  32'h0000_0000, 32'h0000_0005, 4'd1, FAULT_UNDERFLOW);
        add_row(OP_PUSH,       32'h0000_0003, 32'h0000_0003, 4'd2, FAULT_NONE);
        // complement of the top only, the deeper 5 stays
        add_row({1'b0, INEG},  32'h0000_0000, 32'hFFFF_FFFC, 4'd2, FAULT_NONE);
        add_row({1'b0, ISUB},  32'h0000_0000, 32'h0000_0009, 4'd1, FAULT_NONE);
        add_row(OP_PUSH,       32'h0007_0007, 32'h0007_0007, 4'd2, FAULT_NONE);
        add_row(OP_SWAP,       32'h0000_0000, 32'h0000_0009, 4'd2, FAULT_NONE);
        add_row({1'b0, IMUL},  32'h0000_0000, 32'h0000_003F, 4'd1, FAULT_NONE);
        add_row(OP_PUSH,       32'hABCD_0000, 32'hABCD_0000, 4'd2, FAULT_NONE);
        // divisor low half is zero
        add_row({1'b0, IDIV},  32'h0000_0000, 32'hFFFF_FFFF, 4'd1, FAULT_NONE);
        add_row(OP_PUSH,       32'h0001_0000, 32'h0001_0000, 4'd2, FAULT_NONE);
        add_row({1'b0, IREM},  32'h0000_0000, 32'h0000_FFFF, 4'd1, FAULT_NONE);
        add_row(OP_PUSH,       32'h0001_1000, 32'h0001_1000, 4'd2, FAULT_NONE);
        add_row({1'b0, IDIV},  32'h0000_0000, 32'h0000_000F, 4'd1, FAULT_NONE);
        add_row(OP_PUSH,       32'h0005_0004, 32'h0005_0004, 4'd2, FAULT_NONE);
        add_row({1'b0, IREM},  32'h0000_0000, 32'h0000_0003, 4'd1, FAULT_NONE);
        // operands for a chain that folds back down from the top
        add_row(OP_PUSH,       32'h0100_0000, 32'h0100_0000, 4'd2, FAULT_NONE);
        add_row(OP_PUSH,       32'h00FF_FFFF, 32'h00FF_FFFF, 4'd3, FAULT_NONE);
        add_row(OP_PUSH,       32'hFF00_FF00, 32'hFF00_FF00, 4'd4, FAULT_NONE);
        add_row(OP_PUSH,       32'hF0F0_F000, 32'hF0F0_F000, 4'd5, FAULT_NONE);
        add_row(OP_PUSH,       32'hAB00_0000, 32'hAB00_0000, 4'd6, FAULT_NONE);
        add_row(OP_PUSH,       32'h0000_0003, 32'h0000_0003, 4'd7, FAULT_NONE);
        add_row(OP_PUSH,       32'h0000_0023, 32'h0000_0023, 4'd8, FAULT_NONE);
        add_row(OP_DUP,        32'h0000_0000, 32'h0000_0023, 4'd8, FAULT_OVERFLOW);
        add_row(OP_PUSH,       32'h1234_5678, 32'h0000_0023, 4'd8, FAULT_OVERFLOW);
        add_row(5'h1F,         32'h0000_0000, 32'h0000_0023, 4'd8, FAULT_ILLEGAL);
        // shift by 35 acts as a shift by 3
        add_row({1'b0, ISHL},  32'h0000_0000, 32'h0000_0018, 4'd7, FAULT_NONE);
        add_row({1'b0, ISHR},  32'h0000_0000, 32'h0000_00AB, 4'd6, FAULT_NONE);
        add_row({1'b0, IOR},   32'h0000_0000, 32'hF0F0_F0AB, 4'd5, FAULT_NONE);
        add_row({1'b0, IXOR},  32'h0000_0000, 32'h0FF0_0FAB, 4'd4, FAULT_NONE);
        add_row({1'b0, IAND},  32'h0000_0000, 32'h00F0_0FAB, 4'd3, FAULT_NONE);
        add_row({1'b0, ISUB},  32'h0000_0000, 32'h000F_F055, 4'd2, FAULT_NONE);
        add_row({1'b0, IADD},  32'h0000_0000, 32'h000F_F058, 4'd1, FAULT_NONE);
        add_row(OP_DUP,        32'h0000_0000, 32'h000F_F058, 4'd2, FAULT_NONE);
        add_row(OP_POP,        32'h0000_0000, 32'h000F_F058, 4'd1, FAULT_NONE);
        add_row(OP_POP,        32'h0000_0000, 32'h0000_0000, 4'd0, FAULT_NONE);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h at %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic check_idle();
        checks++;
        assert (done === 1'b0) else begin
            errors++;
            $display("done strobe seen with no command pending at %0t", $time);
        end
        check_value("fault", 32'd0, {31'd0, fault});
        check_value("fault_code", 32'd0, {30'd0, fault_code});
    endtask

    task automatic check_response(input word_t exp_tos, input depth_t exp_depth,
                                  input fault_t exp_fault, input int idx);
        checks++;
        assert (done === 1'b1) else begin
            errors++;
            $display("command %0d gave no done strobe in the following cycle", idx);
        end
        check_value("tos", exp_tos, tos);
        check_value("depth", {28'd0, exp_depth}, {28'd0, depth});
        check_value("fault_code", {30'd0, exp_fault}, {30'd0, fault_code});
        check_value("fault", {31'd0, exp_fault != FAULT_NONE}, {31'd0, fault});
    endtask

    task automatic drive_command(input opcode_t op, input word_t imm);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_imm   = imm;
    endtask

    // codes 6, 7, A, B and E have no alu operation
    function automatic logic alu_code_defined(input alu_op_t code);
        return !(code == 4'h6 || code == 4'h7 || code == 4'hA || code == 4'hB || code == 4'hE);
    endfunction

    function automatic word_t expected_alu(input alu_op_t code, input word_t a, input word_t b);
        logic [15:0] a16;
        logic [15:0] b16;
        word_t       r;
        a16 = a[15:0];
        b16 = b[15:0];
        r   = '0;
        if (code == IADD)      r = a + b;
        else if (code == ISUB) r = a + (~b + 32'd1);
        else if (code == IMUL) r = {16'd0, a16} * {16'd0, b16};
        else if (code == IDIV) r = (b16 == 16'd0) ? 32'hFFFF_FFFF : {16'd0, a16 / b16};
        else if (code == IREM) r = (b16 == 16'd0) ? {16'd0, a16} : {16'd0, a16 % b16};
        // ineg is the bitwise complement in this unit
        else if (code == INEG) r = ~a;
        else if (code == IOR)  r = a | b;
        else if (code == IXOR) r = a ^ b;
        else if (code == IAND) r = a & b;
        else if (code == ISHL) r = a << b[4:0];
        else if (code == ISHR) r = a >> b[4:0];
        return r;
    endfunction

    function automatic word_t model_tos();
        if (m_depth == 0) return '0;
        return m_stack[m_depth - 1];
    endfunction

    task automatic model_step(input opcode_t op, input word_t imm, output fault_t f);
        word_t a;
        word_t b;
        f = FAULT_NONE;
        b = model_tos();
        a = (m_depth >= 2) ? m_stack[m_depth - 2] : '0;
        if (op[4] == 1'b0) begin
            if (!alu_code_defined(op[3:0])) begin
                f = FAULT_ILLEGAL;
            end else if (op[3:0] == INEG) begin
                if (m_depth < 1) f = FAULT_UNDERFLOW;
                else m_stack[m_depth - 1] = expected_alu(INEG, b, '0);
            end else if (m_depth < 2) begin
                f = FAULT_UNDERFLOW;
            end else begin
                m_stack[m_depth - 2] = expected_alu(op[3:0], a, b);
                m_depth--;
            end
        end else if (op == OP_PUSH || op == OP_DUP) begin
            if (op == OP_DUP && m_depth < 1) begin
                f = FAULT_UNDERFLOW;
            end else if (m_depth >= STACK_DEPTH) begin
                f = FAULT_OVERFLOW;
            end else begin
                m_stack[m_depth] = (op == OP_PUSH) ? imm : b;
                m_depth++;
            end
        end else if (op == OP_POP) begin
            if (m_depth < 1) f = FAULT_UNDERFLOW;
            else m_depth--;
        end else if (op == OP_SWAP) begin
            if (m_depth < 2) begin
                f = FAULT_UNDERFLOW;
            end else begin
                m_stack[m_depth - 1] = a;
                m_stack[m_depth - 2] = b;
            end
        end else begin
            f = FAULT_ILLEGAL;
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the test did not complete", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : stimulus
        word_t   rand_word;
        opcode_t op;
        word_t   imm;
        word_t   exp_tos;
        depth_t  exp_depth;
        fault_t  exp_fault;
        cmd_valid = 1'b0;
        cmd_op    = '0;
        cmd_imm   = '0;
        errors    = 0;
        checks    = 0;
        row_count = 0;
        m_depth   = 0;
        seed      = 85167;
        fill_table();
        wait (rst_n === 1'b1);

        // quiet outputs after reset
        repeat (3) begin
            @(negedge clk);
            check_idle();
            check_value("tos", 32'd0, tos);
            check_value("depth", 32'd0, {28'd0, depth});
        end

        // one command followed by an idle cycle
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            check_idle();
            drive_command(tbl_op[i], tbl_imm[i]);
            @(negedge clk);
            check_response(tbl_tos[i], tbl_depth[i], tbl_fault[i], i);
            cmd_valid = 1'b0;
        end

        // back to back, the table leaves the stack empty like the model
        @(negedge clk);
        check_idle();
        for (int k = 0; k < RANDOM_CMDS; k++) begin
            rand_word = $random(seed);
            if (rand_word[2:0] < 3'd3) op = OP_PUSH;
            else op = rand_word[8:4];
            imm = $random(seed);
            model_step(op, imm, exp_fault);
            exp_tos   = model_tos();
            exp_depth = depth_t'(m_depth);
            drive_command(op, imm);
            @(negedge clk);
            check_response(exp_tos, exp_depth, exp_fault, NUM_ROWS + k);
        end
        cmd_valid = 1'b0;
        @(negedge clk);
        check_idle();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hw/isa_pkg.sv
hw/stack_pkg.sv
hw/alu.sv
hw/operand_stack.sv
hw/stack_control.sv
hw/stack_core.sv
verification/clk_gen.sv
verification/stack_core_tb.sv

/* Bender.yml */
package:
  name: stack_core

sources:
  - hw/isa_pkg.sv
  - hw/stack_pkg.sv
  - hw/alu.sv
  - hw/operand_stack.sv
  - hw/stack_control.sv
  - hw/stack_core.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/stack_core_tb.sv
